// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and RAM word widths
`define ADDR_W 64
`define DATA_W 64

// RAM size in 64-bit words
`define RAM_WORDS 256

// RAM sits at the usual RV64 DRAM base
`define RAM_BASE 64'h0000_0000_8000_0000

// first fetch comes from the start of RAM
`define RESET_PC `RAM_BASE

// ebreak stops fetching
`define EBREAK_INST 32'h0010_0073

`endif

// ==== src/fetchPkg.sv ====
`include "fetch_cfg.svh"

package fetchPkg;

    // AXI response codes
    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // one instruction handed to the decode stage
    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
        logic [31:0]        inst;
        // RAM answered SLVERR, inst is zero
        logic               fault;
    } fetchPacket;

    // R channel payload from the RAM
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [1:0]         resp;
    } readResp;

    // branch or trap target from execute
    typedef struct packed {
        logic [`ADDR_W-1:0] target;
    } redirectReq;

endpackage

// ==== src/pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    // take a new item when empty or when the held one leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // payload only moves on a handshake, so it stays put under back-pressure
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

// ==== src/pcGen.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pcGen (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   pcAdvance,
    input  logic                   redirectValid,
    input  fetchPkg::redirectReq   redirect,
    output logic [`ADDR_W-1:0]     pc
);

    // pc is always the address of the next fetch to issue
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else if (redirectValid) begin
            // redirect beats a sequential step
            pc <= redirect.target;
        end else if (pcAdvance) begin
            pc <= pc + `ADDR_W'(4);
        end
    end

endmodule

// ==== src/ifu.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ifu (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   fetchEn,
    input  logic [`ADDR_W-1:0]     pc,
    output logic                   pcAdvance,
    input  logic                   redirectValid,
    output logic                   arvalid,
    output logic [`ADDR_W-1:0]     araddr,
    input  logic                   arready,
    input  logic                   rvalid,
    input  fetchPkg::readResp      rresp,
    output logic                   rready,
    output logic                   instValid,
    output fetchPkg::fetchPacket   instOut,
    input  logic                   instReady,
    output logic                   halted
);
    import fetchPkg::*;

    localparam logic [1:0] maxOutstanding = 2'd2;

    logic [`ADDR_W-1:0] pcQ [2];
    logic [`ADDR_W-1:0] headPc;
    logic               wrPtr;
    logic               rdPtr;
    logic [1:0]         outCnt;
    logic [1:0]         dropCnt;
    logic               ebreakSeen;
    logic               issue;
    logic               rFire;
    logic               dropResp;
    logic               pktInValid;
    logic               pktInReady;
    fetchPacket         pkt;

    // no new fetch while redirecting, halting, full, or the output is stuck
    assign issue = fetchEn && !halted && !ebreakSeen && !redirectValid
                   && (outCnt != maxOutstanding)
                   && !(instValid && !instReady)
                   && (!arvalid || arready);
    assign pcAdvance = issue;

    // AR is registered so address stays stable until arready
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            arvalid <= 1'b0;
            araddr  <= '0;
        end else if (issue) begin
            arvalid <= 1'b1;
            araddr  <= {pc[`ADDR_W-1:3], 3'b000};
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    // pc of every fetch in flight, oldest at rdPtr
    always_ff @(posedge clk) begin
        if (issue) begin
            pcQ[wrPtr] <= pc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr  <= 1'b0;
            rdPtr  <= 1'b0;
            outCnt <= 2'd0;
        end else begin
            if (issue) begin
                wrPtr <= !wrPtr;
            end
            if (rFire) begin
                rdPtr <= !rdPtr;
            end
            outCnt <= outCnt + {1'b0, issue} - {1'b0, rFire};
        end
    end

    // stale responses are swallowed without waiting on the output slice
    assign dropResp   = redirectValid || (dropCnt != 2'd0) || ebreakSeen;
    assign rready     = dropResp || pktInReady;
    assign rFire      = rvalid && rready;
    assign pktInValid = rvalid && !dropResp;

    // everything still in flight at a redirect is dead
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dropCnt <= 2'd0;
        end else if (redirectValid) begin
            dropCnt <= outCnt - {1'b0, rFire};
        end else if (rFire && dropCnt != 2'd0) begin
            dropCnt <= dropCnt - 2'd1;
        end
    end

    // pick the 32-bit half by pc bit 2
    assign headPc = pcQ[rdPtr];

    always_comb begin
        pkt.pc    = headPc;
        pkt.fault = (rresp.resp == respSlvErr);
        if (pkt.fault) begin
            pkt.inst = 32'd0;
        end else if (headPc[2]) begin
            pkt.inst = rresp.data[32 +: 32];
        end else begin
            pkt.inst = rresp.data[0 +: 32];
        end
    end

    // packets already presented downstream are not recalled
    pipeReg #(
        .payloadT (fetchPacket)
    ) outSlice (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (pktInValid),
        .inData   (pkt),
        .inReady  (pktInReady),
        .outValid (instValid),
        .outData  (instOut),
        .outReady (instReady)
    );

    // once ebreak is queued, later fetches are wrong-path
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ebreakSeen <= 1'b0;
            halted     <= 1'b0;
        end else begin
            if (pktInValid && pktInReady && !pkt.fault && pkt.inst == `EBREAK_INST) begin
                ebreakSeen <= 1'b1;
            end
            if (instValid && instReady && !instOut.fault && instOut.inst == `EBREAK_INST) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== src/axiLiteRam.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module axiLiteRam (
    input  logic                     clk,
    input  logic                     arstN,
    // write side, used for loading
    input  logic                     awvalid,
    input  logic [`ADDR_W-1:0]       awaddr,
    output logic                     awready,
    input  logic                     wvalid,
    input  logic [`DATA_W-1:0]       wdata,
    input  logic [`DATA_W/8-1:0]     wstrb,
    output logic                     wready,
    output logic                     bvalid,
    output logic [1:0]               bresp,
    input  logic                     bready,
    // read side, driven by the fetch unit
    input  logic                     arvalid,
    input  logic [`ADDR_W-1:0]       araddr,
    output logic                     arready,
    output logic                     rvalid,
    output fetchPkg::readResp        rresp,
    input  logic                     rready
);
    import fetchPkg::*;

    localparam int idxW = $clog2(`RAM_WORDS);

    logic [`DATA_W-1:0] mem [`RAM_WORDS];
    logic               wrFire;
    logic               arFire;

    function automatic logic inRange(input logic [`ADDR_W-1:0] addr);
        logic [`ADDR_W-1:0] offset;
        offset = addr - `RAM_BASE;
        return (addr >= `RAM_BASE) && (offset < `ADDR_W'(`RAM_WORDS * 8));
    endfunction

    function automatic logic [idxW-1:0] wordIdx(input logic [`ADDR_W-1:0] addr);
        logic [`ADDR_W-1:0] offset;
        offset = addr - `RAM_BASE;
        return offset[3 +: idxW];
    endfunction

    // AW and W go together, and only once the previous B is gone
    assign wrFire  = awvalid && wvalid && (!bvalid || bready);
    assign awready = wrFire;
    assign wready  = wrFire;

    always_ff @(posedge clk) begin
        if (wrFire && inRange(awaddr)) begin
            for (int b = 0; b < `DATA_W / 8; b++) begin
                if (wstrb[b]) begin
                    mem[wordIdx(awaddr)][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bvalid <= 1'b0;
            bresp  <= respOkay;
        end else if (wrFire) begin
            bvalid <= 1'b1;
            bresp  <= inRange(awaddr) ? respOkay : respSlvErr;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // single-entry read return, next AR may land as R leaves
    assign arready = !rvalid || rready;
    assign arFire  = arvalid && arready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
        end else if (arFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arFire) begin
            if (inRange(araddr)) begin
                rresp.data <= mem[wordIdx(araddr)];
                rresp.resp <= respOkay;
            end else begin
                rresp.data <= '0;
                rresp.resp <= respSlvErr;
            end
        end
    end

endmodule

// ==== src/fetchTop.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchTop (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     fetchEn,
    // redirect from execute
    input  logic                     redirectValid,
    input  fetchPkg::redirectReq     redirect,
    output logic                     redirectReady,
    // RAM load port
    input  logic                     awvalid,
    input  logic [`ADDR_W-1:0]       awaddr,
    output logic                     awready,
    input  logic                     wvalid,
    input  logic [`DATA_W-1:0]       wdata,
    input  logic [`DATA_W/8-1:0]     wstrb,
    output logic                     wready,
    output logic                     bvalid,
    output logic [1:0]               bresp,
    input  logic                     bready,
    // instruction stream out
    output logic                     instValid,
    output fetchPkg::fetchPacket     instOut,
    input  logic                     instReady,
    output logic                     halted
);
    import fetchPkg::*;

    logic [`ADDR_W-1:0] pc;
    logic               pcAdvance;
    logic               arvalid;
    logic [`ADDR_W-1:0] araddr;
    logic               arready;
    logic               ramRvalid;
    logic               ramRready;
    readResp            ramRresp;
    logic               rvalid;
    logic               rready;
    readResp            rresp;

    // redirects are never refused
    assign redirectReady = 1'b1;

    pcGen pcGenU (
        .clk           (clk),
        .arstN         (arstN),
        .pcAdvance     (pcAdvance),
        .redirectValid (redirectValid),
        .redirect      (redirect),
        .pc            (pc)
    );

    ifu ifuU (
        .clk           (clk),
        .arstN         (arstN),
        .fetchEn       (fetchEn),
        .pc            (pc),
        .pcAdvance     (pcAdvance),
        .redirectValid (redirectValid),
        .arvalid       (arvalid),
        .araddr        (araddr),
        .arready       (arready),
        .rvalid        (rvalid),
        .rresp         (rresp),
        .rready        (rready),
        .instValid     (instValid),
        .instOut       (instOut),
        .instReady     (instReady),
        .halted        (halted)
    );

    axiLiteRam ramU (
        .clk     (clk),
        .arstN   (arstN),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (ramRvalid),
        .rresp   (ramRresp),
        .rready  (ramRready)
    );

    // R channel slice between RAM and fetch unit
    pipeReg #(
        .payloadT (readResp)
    ) respSlice (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (ramRvalid),
        .inData   (ramRresp),
        .inReady  (ramRready),
        .outValid (rvalid),
        .outData  (rresp),
        .outReady (rready)
    );

endmodule

// ==== sim/fetch_asserts.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchAsserts (
    input logic                   clk,
    input logic                   arstN,
    input logic                   arvalid,
    input logic [`ADDR_W-1:0]     araddr,
    input logic                   arready,
    input logic                   pcAdvance,
    input logic [`ADDR_W-1:0]     pc,
    input logic                   instValid,
    input logic                   instReady,
    input fetchPkg::fetchPacket   instOut,
    input logic                   halted
);

    // AR held until the RAM takes it
    arHeld: assert property (@(posedge clk) disable iff (!arstN)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR request changed before arready");

    // packet frozen while downstream stalls
    instHeld: assert property (@(posedge clk) disable iff (!arstN)
        instValid && !instReady |=> instValid && $stable(instOut))
        else $error("instruction packet changed under back-pressure");

    // every fetch starts on a 32-bit instruction boundary
    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pcAdvance |-> pc[1:0] == 2'b00)
        else $error("fetch issued from a pc that is not 4-byte aligned");

    // once halted, only an AR still waiting for arready may remain
    noIssueHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> !arvalid || $past(arvalid && !arready))
        else $error("new AR issued after halt");

endmodule

bind ifu fetchAsserts ifuChecks (
    .clk       (clk),
    .arstN     (arstN),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .pcAdvance (pcAdvance),
    .pc        (pc),
    .instValid (instValid),
    .instReady (instReady),
    .instOut   (instOut),
    .halted    (halted)
);

// ==== sim/fetchTb.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetchTb;
    import fetchPkg::*;

    localparam int idxW = $clog2(`RAM_WORDS);
    localparam int seqPkts = 64;
    localparam int strbWords = 16;
    localparam int strbBase = 128;
    localparam int bpPkts = 64;
    localparam int numRedirects = 8;
    localparam int pktsPerRedirect = 8;
    localparam int faultPkts = 4;
    localparam int haltWord = 100;
    localparam int haltPkts = 10;
    localparam int expectedPkts = seqPkts + 2 * strbWords + bpPkts
                                  + numRedirects * pktsPerRedirect + faultPkts + haltPkts;
    localparam int cycleLimit = 40 * expectedPkts + 2000;

    logic               clk = 1'b0;
    logic               arstN;
    logic               fetchEn;
    logic               redirectValid;
    redirectReq         redirect;
    logic               redirectReady;
    logic               awvalid;
    logic [`ADDR_W-1:0] awaddr;
    logic               awready;
    logic               wvalid;
    logic [`DATA_W-1:0] wdata;
    logic [7:0]         wstrb;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               bready;
    logic               instValid;
    fetchPacket         instOut;
    logic               instReady = 1'b1;
    logic               halted;

    // reference memory and random sources
    logic [`DATA_W-1:0] model [`RAM_WORDS];
    logic [31:0]        lfsr = 32'he6d82412;
    logic [31:0]        bpState = 32'he6d82412;
    logic               bpMode;
    logic               readyLevel;

    // owned by the packet monitor
    logic [`ADDR_W-1:0] expPc = `RESET_PC;
    logic [`ADDR_W-1:0] stalePc = '0;
    logic               staleValid = 1'b0;
    logic               haltSeen = 1'b0;
    int                 pktCount = 0;
    int                 cycles = 0;
    int                 monErrors = 0;

    int                 mainErrors = 0;
    int                 testErrStart;
    int                 testsPassed = 0;
    int                 testsFailed = 0;
    string              testName = "reset";

    fetchTop uut (
        .clk           (clk),
        .arstN         (arstN),
        .fetchEn       (fetchEn),
        .redirectValid (redirectValid),
        .redirect      (redirect),
        .redirectReady (redirectReady),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wready        (wready),
        .bvalid        (bvalid),
        .bresp         (bresp),
        .bready        (bready),
        .instValid     (instValid),
        .instOut       (instOut),
        .instReady     (instReady),
        .halted        (halted)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic logic [63:0] randBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = galoisStep(lfsr);
        end
        return v;
    endfunction

    function automatic logic [63:0] randWord();
        logic [63:0] w;
        w = randBits(64);
        while (w[31:0] == `EBREAK_INST || w[63:32] == `EBREAK_INST) begin
            w = randBits(64);
        end
        return w;
    endfunction

    // what the stage should deliver for a given pc
    function automatic fetchPacket expectFor(input logic [`ADDR_W-1:0] pc);
        fetchPacket         p;
        logic [`ADDR_W-1:0] offset;
        logic [`DATA_W-1:0] word;
        offset = pc - `RAM_BASE;
        p.pc = pc;
        if (pc < `RAM_BASE || offset >= 64'(`RAM_WORDS) * 64'd8) begin
            p.fault = 1'b1;
            p.inst  = '0;
        end else begin
            word    = model[offset[3 +: idxW]];
            p.fault = 1'b0;
            p.inst  = pc[2] ? word[63:32] : word[31:0];
        end
        return p;
    endfunction

    task automatic checkVal(input string what, input logic [63:0] expVal,
                            input logic [63:0] actVal, inout int errCount);
        if (expVal !== actVal) begin
            errCount++;
            $display("mismatch in %s, %s: expected %h, actual %h",
                     testName, what, expVal, actVal);
        end
    endtask

    task automatic comparePacket(input fetchPacket exp);
        checkVal("pc", exp.pc, instOut.pc, monErrors);
        checkVal("inst", 64'(exp.inst), 64'(instOut.inst), monErrors);
        checkVal("fault", 64'(exp.fault), 64'(instOut.fault), monErrors);
    endtask

    // packet monitor sampling at the edge where the handshake happens
    always @(posedge clk) begin
        cycles++;
        if (arstN) begin
            if (instValid && instReady) begin
                pktCount++;
                if (haltSeen) begin
                    monErrors++;
                    $display("packet at pc %h arrived after the ebreak in %s",
                             instOut.pc, testName);
                end else if (staleValid) begin
                    // held in the output slice when the redirect came
                    staleValid = 1'b0;
                    comparePacket(expectFor(stalePc));
                end else begin
                    comparePacket(expectFor(expPc));
                    if (!expectFor(expPc).fault && expectFor(expPc).inst == `EBREAK_INST) begin
                        haltSeen = 1'b1;
                    end
                    expPc = expPc + 64'd4;
                end
            end
            if (redirectValid) begin
                if (instValid && !instReady && !staleValid) begin
                    staleValid = 1'b1;
                    stalePc    = expPc;
                end
                expPc = redirect.target;
            end
        end
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles in %s", cycles, testName);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // downstream ready goes random under back-pressure
    always @(posedge clk) begin
        if (bpMode) begin
            instReady <= bpState[0];
            bpState   <= galoisStep(bpState);
        end else begin
            instReady <= readyLevel;
        end
    end

    task automatic startTest(input string name);
        testName     = name;
        testErrStart = mainErrors + monErrors;
    endtask

    task automatic endTest();
        int n;
        n = mainErrors + monErrors - testErrStart;
        if (n == 0) begin
            testsPassed++;
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", testName, n);
        end
    endtask

    task automatic waitPackets(input int n);
        int goal;
        @(negedge clk);
        goal = pktCount + n;
        wait (pktCount >= goal);
        @(posedge clk);
    endtask

    task automatic writeWord(input int idx, input logic [63:0] data, input logic [7:0] strb);
        awvalid <= 1'b1;
        awaddr  <= `RAM_BASE + 64'(idx) * 64'd8;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        do @(posedge clk); while (!awready);
        // W is taken in the same cycle as AW
        checkVal("wready", 64'd1, 64'(wready), mainErrors);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        checkVal("bresp", 64'(respOkay), 64'(bresp), mainErrors);
    endtask

    task automatic redirectTo(input logic [`ADDR_W-1:0] target);
        redirectValid   <= 1'b1;
        redirect.target <= target;
        @(posedge clk);
        // the fetch unit takes every redirect
        checkVal("redirectReady", 64'd1, 64'(redirectReady), mainErrors);
        redirectValid <= 1'b0;
    endtask

    task automatic loadRam();
        logic [63:0] w;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            w = randWord();
            model[i] = w;
            writeWord(i, w, 8'hFF);
        end
    endtask

    task automatic strobeWrites();
        logic [63:0] data;
        logic [63:0] merged;
        logic [7:0]  strb;
        // stall fetch so no read races the writes
        readyLevel <= 1'b0;
        wait (instValid && !instReady);
        @(posedge clk);
        for (int i = 0; i < strbWords; i++) begin
            do begin
                data   = randBits(64);
                strb   = 8'(randBits(8)) & ~(8'd1 << (i % 8));
                merged = model[strbBase + i];
                for (int b = 0; b < 8; b++) begin
                    if (strb[b]) begin
                        merged[8*b +: 8] = data[8*b +: 8];
                    end
                end
            end while (merged[31:0] == `EBREAK_INST || merged[63:32] == `EBREAK_INST);
            model[strbBase + i] = merged;
            writeWord(strbBase + i, data, strb);
        end
        readyLevel <= 1'b1;
        redirectTo(`RAM_BASE + 64'(strbBase) * 64'd8);
        waitPackets(2 * strbWords);
    endtask

    task automatic randomRedirects();
        int gap;
        int idx;
        for (int r = 0; r < numRedirects; r++) begin
            gap = int'(randBits(4));
            repeat (gap) @(posedge clk);
            idx = int'(randBits(idxW));
            if (idx >= `RAM_WORDS - 16) begin
                idx = idx - 128;
            end
            redirectTo(`RAM_BASE + 64'(idx) * 64'd8 + randBits(1) * 64'd4);
            waitPackets(pktsPerRedirect);
        end
    endtask

    task automatic haltOnEbreak();
        logic [63:0] w;
        w = randWord();
        w[63:32] = `EBREAK_INST;
        model[haltWord] = w;
        writeWord(haltWord, w, 8'hFF);
        redirectTo(`RAM_BASE + 64'(haltWord - 4) * 64'd8);
        wait (halted);
        @(posedge clk);
        checkVal("ebreak delivered", 64'd1, 64'(haltSeen), mainErrors);
        // monitor flags anything that still shows up
        repeat (50) @(posedge clk);
        checkVal("halted", 64'd1, 64'(halted), mainErrors);
    endtask

    initial begin
        arstN         = 1'b0;
        fetchEn       = 1'b0;
        redirectValid = 1'b0;
        redirect      = '0;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        bready        = 1'b1;
        bpMode        = 1'b0;
        readyLevel    = 1'b1;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);

        startTest("sequential fetch");
        checkVal("instValid after reset", 64'd0, 64'(instValid), mainErrors);
        checkVal("halted after reset", 64'd0, 64'(halted), mainErrors);
        loadRam();
        fetchEn <= 1'b1;
        waitPackets(seqPkts);
        endTest();

        startTest("byte strobes");
        strobeWrites();
        endTest();

        startTest("back-pressure");
        bpMode <= 1'b1;
        waitPackets(bpPkts);
        endTest();

        startTest("redirect");
        randomRedirects();
        endTest();

        startTest("fault");
        redirectTo(`RAM_BASE + 64'(`RAM_WORDS) * 64'd8 + 64'd16);
        waitPackets(faultPkts);
        endTest();

        startTest("halt");
        haltOnEbreak();
        endTest();

        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 testsPassed, testsFailed, mainErrors + monErrors);
        if (testsFailed == 0 && mainErrors + monErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
src/fetchPkg.sv
src/pipeReg.sv
src/pcGen.sv
src/ifu.sv
src/axiLiteRam.sv
src/fetchTop.sv
sim/fetch_asserts.sv
sim/fetchTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetchTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv sim/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
